// ==== design/chk_sched_pkg.sv ====
// Shared widths, seed, vector types, configuration and counter-control structs, state enum
`default_nettype none

package chk_sched_pkg;

  ////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////

  // LFSR and both wait counters
  parameter int unsigned LfsrWidth = 40;
  // Software masks and check timeout
  parameter int unsigned PeriodWidth = 32;
  // Entropy word, only the low LfsrWidth bits feed the LFSR
  parameter int unsigned EdnDataWidth = 64;

  // Nonzero start value of the LFSR
  parameter logic [LfsrWidth-1:0] LfsrSeed = 40'h5a_c3e1_9b27;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [LfsrWidth-1:0] lfsr_t;
  typedef logic [PeriodWidth-1:0] period_t;

  // Software configuration, expected stable while the timer runs
  typedef struct packed {
    // Zero disables the check timeout
    period_t timeout;
    // Zero disables periodic integrity checks
    period_t integ_msk;
    // Zero disables periodic consistency checks
    period_t cnsty_msk;
  } chk_cfg_t;

  // Per-counter control from the FSM
  typedef struct packed {
    // Draw a new wait period from the LFSR
    logic load_period;
    // Start the check timeout
    logic load_timeout;
    // Hold the count, honoured only by counters built with pause support
    logic pause;
  } cnt_ctrl_t;

  // Scheduler states
  typedef enum logic [2:0] {
    ResetSt,
    IdleSt,
    IntegWaitSt,
    CnstyWaitSt,
    ErrorSt
  } chk_state_e;

endpackage

`default_nettype wire

// ==== design/lfsr_period_gen.sv ====
// Reseed timer with entropy request/ack, and the entropy-fed 40-bit Galois LFSR
`timescale 1ns/1ps
`default_nettype none

module lfsr_period_gen #(
  parameter int unsigned ReseedWidth = 16
) (
  input  wire                                     clk_i,
  input  wire                                     rst_ni,
  input  wire                                     edn_ack_i,
  input  wire  [chk_sched_pkg::EdnDataWidth-1:0]  edn_data_i,
  input  wire                                     lfsr_step_i,
  output logic                                    edn_req_o,
  output chk_sched_pkg::lfsr_t                    lfsr_state_o
);

  // Taps of x^40 + x^38 + x^21 + x^19 + 1, right-shifting Galois form
  localparam chk_sched_pkg::lfsr_t LfsrTaps = 40'ha0_0014_0000;

  ////////////////////////////////////////
  // Reseed timer
  ////////////////////////////////////////

  logic [ReseedWidth-1:0] reseed_timer_d, reseed_timer_q;
  logic                   reseed_en;

  // Request stays up while the timer sits at zero
  assign edn_req_o = (reseed_timer_q == '0);
  assign reseed_en = edn_req_o & edn_ack_i;

  always_comb begin
    if (reseed_timer_q != '0) begin
      reseed_timer_d = reseed_timer_q - 1'b1;
    end else if (reseed_en) begin
      reseed_timer_d = {ReseedWidth{1'b1}};
    end else begin
      // Entropy source not ready yet, keep asking
      reseed_timer_d = '0;
    end
  end

  ////////////////////////////////////////
  // LFSR
  ////////////////////////////////////////

  chk_sched_pkg::lfsr_t lfsr_d, lfsr_q, lfsr_mixed, lfsr_next;

  // Fold in entropy only on a completed handshake
  assign lfsr_mixed = reseed_en ? (lfsr_q ^ edn_data_i[chk_sched_pkg::LfsrWidth-1:0]) : lfsr_q;

  // One Galois step, feedback from bit 0
  assign lfsr_next = (lfsr_mixed >> 1) ^ (lfsr_mixed[0] ? LfsrTaps : '0);

  always_comb begin
    lfsr_d = lfsr_q;
    if (reseed_en || lfsr_step_i) begin
      lfsr_d = lfsr_next;
      // Entropy may cancel the state, restart from the seed rather than lock up
      if (lfsr_next == '0) begin
        lfsr_d = chk_sched_pkg::LfsrSeed;
      end
    end
  end

  assign lfsr_state_o = lfsr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reseed_timer_q <= {ReseedWidth{1'b1}};
      lfsr_q         <= chk_sched_pkg::LfsrSeed;
    end else begin
      reseed_timer_q <= reseed_timer_d;
      lfsr_q         <= lfsr_d;
    end
  end

  // A served reseed restarts the full timer period
  a_reseed_drops_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    reseed_en |=> !edn_req_o
  );

endmodule

`default_nettype wire

// ==== design/chk_wait_counter.sv ====
// One 40-bit countdown counter loading a masked LFSR period or a timeout, optional pause
`timescale 1ns/1ps
`default_nettype none

module chk_wait_counter #(
  parameter bit PauseEn = 1'b0
) (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  chk_sched_pkg::cnt_ctrl_t  ctrl_i,
  input  chk_sched_pkg::lfsr_t      lfsr_state_i,
  input  chk_sched_pkg::period_t    msk_i,
  input  chk_sched_pkg::period_t    timeout_i,
  output logic                      cnt_zero_o
);

  localparam int unsigned ExtBits = chk_sched_pkg::LfsrWidth - chk_sched_pkg::PeriodWidth;

  chk_sched_pkg::lfsr_t cnt_d, cnt_q;
  chk_sched_pkg::lfsr_t period_msk;

  // Software mask sits above eight always-set low bits
  assign period_msk = {msk_i, {ExtBits{1'b1}}};

  assign cnt_zero_o = (cnt_q == '0);

  always_comb begin
    if (ctrl_i.load_period) begin
      cnt_d = lfsr_state_i & period_msk;
    end else if (ctrl_i.load_timeout) begin
      cnt_d = chk_sched_pkg::LfsrWidth'(timeout_i);
    end else if (cnt_zero_o) begin
      // Expired, stay at zero
      cnt_d = '0;
    end else if (PauseEn && ctrl_i.pause) begin
      cnt_d = cnt_q;
    end else begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // A counter serves either as period or as timeout, never both in one cycle
  a_single_load: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(ctrl_i.load_period && ctrl_i.load_timeout)
  );

endmodule

`default_nettype wire

// ==== design/chk_req_tracker.sv ====
// One-off trigger latch and per-partition request register for one check kind
`timescale 1ns/1ps
`default_nettype none

module chk_req_tracker #(
  parameter int unsigned NumPart = 4
) (
  input  wire                clk_i,
  input  wire                rst_ni,
  input  wire                trig_i,
  input  wire                clear_trig_i,
  input  wire                start_i,
  input  wire  [NumPart-1:0] ack_i,
  output logic               trig_pending_o,
  output logic               all_done_o,
  output logic [NumPart-1:0] req_o
);

  logic               trig_d, trig_q;
  logic [NumPart-1:0] req_d, req_q;

  ////////////////////////////////////////
  // Trigger latch
  ////////////////////////////////////////

  // A fresh pulse wins over a clear in the same cycle
  assign trig_d = (trig_q & ~clear_trig_i) | trig_i;

  ////////////////////////////////////////
  // Partition requests
  ////////////////////////////////////////

  // All bits set together, each dropped by its own ack
  // Acks on idle bits fall out of the AND
  assign req_d = start_i ? {NumPart{1'b1}} : (req_q & ~ack_i);

  assign trig_pending_o = trig_q;
  assign all_done_o     = (req_q == '0);
  assign req_o          = req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trig_q <= 1'b0;
      req_q  <= '0;
    end else begin
      trig_q <= trig_d;
      req_q  <= req_d;
    end
  end

  // New request bits only follow a start from the FSM
  a_req_needs_start: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !start_i |=> ((req_o & ~$past(req_o)) == '0)
  );

endmodule

`default_nettype wire

// ==== design/chk_sched_fsm.sv ====
// Check scheduling FSM with counter control, trigger clears and the timeout flag
`timescale 1ns/1ps
`default_nettype none

module chk_sched_fsm (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire                       timer_en_i,
  input  wire                       prog_busy_i,
  input  wire                       escalate_i,
  input  chk_sched_pkg::chk_cfg_t   cfg_i,
  input  wire                       integ_zero_i,
  input  wire                       cnsty_zero_i,
  input  wire                       integ_trig_pending_i,
  input  wire                       cnsty_trig_pending_i,
  input  wire                       integ_done_i,
  input  wire                       cnsty_done_i,
  output logic                      lfsr_step_o,
  output chk_sched_pkg::cnt_ctrl_t  integ_ctrl_o,
  output chk_sched_pkg::cnt_ctrl_t  cnsty_ctrl_o,
  output logic                      integ_start_o,
  output logic                      cnsty_start_o,
  output logic                      integ_clear_trig_o,
  output logic                      cnsty_clear_trig_o,
  output logic                      chk_pending_o,
  output logic                      chk_timeout_o,
  output logic                      fsm_err_o
);

  chk_sched_pkg::chk_state_e state_d, state_q;
  logic                      timeout_d, timeout_q;
  logic                      timeout_zero, integ_msk_zero, cnsty_msk_zero;

  // Disable conditions straight from the configuration
  assign timeout_zero   = (cfg_i.timeout == '0);
  assign integ_msk_zero = (cfg_i.integ_msk == '0);
  assign cnsty_msk_zero = (cfg_i.cnsty_msk == '0);

  ////////////////////////////////////////
  // Next state and controls
  ////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    timeout_d          = timeout_q;
    lfsr_step_o        = 1'b0;
    integ_ctrl_o       = '0;
    cnsty_ctrl_o       = '0;
    integ_start_o      = 1'b0;
    cnsty_start_o      = 1'b0;
    integ_clear_trig_o = 1'b0;
    cnsty_clear_trig_o = 1'b0;

    case (state_q)
      // Parked until software enables the timer and never re-entered
      chk_sched_pkg::ResetSt: begin
        if (timer_en_i) begin
          state_d     = chk_sched_pkg::IdleSt;
          lfsr_step_o = 1'b1;
        end
      end
      // Integrity first when both kinds are due
      chk_sched_pkg::IdleSt: begin
        if ((!integ_msk_zero && integ_zero_i) || integ_trig_pending_i) begin
          state_d                   = chk_sched_pkg::IntegWaitSt;
          integ_start_o             = 1'b1;
          integ_ctrl_o.load_timeout = 1'b1;
          integ_clear_trig_o        = integ_trig_pending_i;
        end else if ((!cnsty_msk_zero && cnsty_zero_i) || cnsty_trig_pending_i) begin
          state_d                   = chk_sched_pkg::CnstyWaitSt;
          cnsty_start_o             = 1'b1;
          cnsty_ctrl_o.load_timeout = 1'b1;
          cnsty_clear_trig_o        = cnsty_trig_pending_i;
        end
      end
      // Counter runs as timeout here
      chk_sched_pkg::IntegWaitSt: begin
        if (!timeout_zero && integ_zero_i) begin
          state_d   = chk_sched_pkg::ErrorSt;
          timeout_d = 1'b1;
        end else if (integ_done_i) begin
          // All partitions answered so draw the next period
          state_d                  = chk_sched_pkg::IdleSt;
          integ_ctrl_o.load_period = 1'b1;
          lfsr_step_o              = 1'b1;
        end
      end
      chk_sched_pkg::CnstyWaitSt: begin
        // Consistency reads compete with programming and stretch the timeout
        cnsty_ctrl_o.pause = prog_busy_i;
        if (!timeout_zero && cnsty_zero_i) begin
          state_d   = chk_sched_pkg::ErrorSt;
          timeout_d = 1'b1;
        end else if (cnsty_done_i) begin
          state_d                  = chk_sched_pkg::IdleSt;
          cnsty_ctrl_o.load_period = 1'b1;
          lfsr_step_o              = 1'b1;
        end
      end
      // Terminal state swallows any trigger that arrives
      chk_sched_pkg::ErrorSt: begin
        integ_clear_trig_o = 1'b1;
        cnsty_clear_trig_o = 1'b1;
      end
      default: begin
        state_d = chk_sched_pkg::ErrorSt;
      end
    endcase

    // Escalation overrides everything
    if (escalate_i) begin
      state_d = chk_sched_pkg::ErrorSt;
    end
  end

  ////////////////////////////////////////
  // Status outputs
  ////////////////////////////////////////

  assign chk_pending_o = integ_trig_pending_i || cnsty_trig_pending_i ||
                         (state_q == chk_sched_pkg::IntegWaitSt) ||
                         (state_q == chk_sched_pkg::CnstyWaitSt);
  assign chk_timeout_o = timeout_q;
  // Error state reached by escalation only
  assign fsm_err_o     = (state_q == chk_sched_pkg::ErrorSt) && !timeout_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= chk_sched_pkg::ResetSt;
      timeout_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      timeout_q <= timeout_d;
    end
  end

  // Starts come from idle only after both trackers have seen every ack
  a_integ_start_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    integ_start_o |-> (state_q == chk_sched_pkg::IdleSt) && integ_done_i && cnsty_done_i
  );
  a_cnsty_start_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnsty_start_o |-> (state_q == chk_sched_pkg::IdleSt) && integ_done_i && cnsty_done_i
  );

endmodule

`default_nettype wire

// ==== design/chk_sched_top.sv ====
// Check scheduler top level with period generator, two wait counters, two trackers and the FSM
`timescale 1ns/1ps
`default_nettype none

module chk_sched_top #(
  parameter int unsigned NumPart     = 4,
  parameter int unsigned ReseedWidth = 16
) (
  input  wire                                     clk_i,
  input  wire                                     rst_ni,
  input  wire                                     edn_ack_i,
  input  wire  [chk_sched_pkg::EdnDataWidth-1:0]  edn_data_i,
  input  wire                                     timer_en_i,
  input  wire                                     prog_busy_i,
  input  wire                                     integ_trig_i,
  input  wire                                     cnsty_trig_i,
  input  wire                                     escalate_i,
  input  chk_sched_pkg::chk_cfg_t                 cfg_i,
  input  wire  [NumPart-1:0]                      integ_ack_i,
  input  wire  [NumPart-1:0]                      cnsty_ack_i,
  output logic                                    edn_req_o,
  output logic                                    chk_pending_o,
  output logic                                    chk_timeout_o,
  output logic                                    fsm_err_o,
  output logic [NumPart-1:0]                      integ_req_o,
  output logic [NumPart-1:0]                      cnsty_req_o
);

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  chk_sched_pkg::lfsr_t     lfsr_state;
  logic                     lfsr_step;
  chk_sched_pkg::cnt_ctrl_t integ_ctrl, cnsty_ctrl;
  logic                     integ_zero, cnsty_zero;
  logic                     integ_start, cnsty_start;
  logic                     integ_clear_trig, cnsty_clear_trig;
  logic                     integ_trig_pending, cnsty_trig_pending;
  logic                     integ_done, cnsty_done;

  // Random period source, reseeded from the entropy handshake
  lfsr_period_gen #(
    .ReseedWidth (ReseedWidth)
  ) u_period_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .edn_ack_i    (edn_ack_i),
    .edn_data_i   (edn_data_i),
    .lfsr_step_i  (lfsr_step),
    .edn_req_o    (edn_req_o),
    .lfsr_state_o (lfsr_state)
  );

  ////////////////////////////////////////
  // Wait counters
  ////////////////////////////////////////

  chk_wait_counter #(
    .PauseEn (1'b0)
  ) u_integ_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctrl_i       (integ_ctrl),
    .lfsr_state_i (lfsr_state),
    .msk_i        (cfg_i.integ_msk),
    .timeout_i    (cfg_i.timeout),
    .cnt_zero_o   (integ_zero)
  );

  // Consistency timeout freezes during programming
  chk_wait_counter #(
    .PauseEn (1'b1)
  ) u_cnsty_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctrl_i       (cnsty_ctrl),
    .lfsr_state_i (lfsr_state),
    .msk_i        (cfg_i.cnsty_msk),
    .timeout_i    (cfg_i.timeout),
    .cnt_zero_o   (cnsty_zero)
  );

  ////////////////////////////////////////
  // Request trackers
  ////////////////////////////////////////

  chk_req_tracker #(
    .NumPart (NumPart)
  ) u_integ_trk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .trig_i         (integ_trig_i),
    .clear_trig_i   (integ_clear_trig),
    .start_i        (integ_start),
    .ack_i          (integ_ack_i),
    .trig_pending_o (integ_trig_pending),
    .all_done_o     (integ_done),
    .req_o          (integ_req_o)
  );

  chk_req_tracker #(
    .NumPart (NumPart)
  ) u_cnsty_trk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .trig_i         (cnsty_trig_i),
    .clear_trig_i   (cnsty_clear_trig),
    .start_i        (cnsty_start),
    .ack_i          (cnsty_ack_i),
    .trig_pending_o (cnsty_trig_pending),
    .all_done_o     (cnsty_done),
    .req_o          (cnsty_req_o)
  );

  // Scheduler control
  chk_sched_fsm u_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .timer_en_i           (timer_en_i),
    .prog_busy_i          (prog_busy_i),
    .escalate_i           (escalate_i),
    .cfg_i                (cfg_i),
    .integ_zero_i         (integ_zero),
    .cnsty_zero_i         (cnsty_zero),
    .integ_trig_pending_i (integ_trig_pending),
    .cnsty_trig_pending_i (cnsty_trig_pending),
    .integ_done_i         (integ_done),
    .cnsty_done_i         (cnsty_done),
    .lfsr_step_o          (lfsr_step),
    .integ_ctrl_o         (integ_ctrl),
    .cnsty_ctrl_o         (cnsty_ctrl),
    .integ_start_o        (integ_start),
    .cnsty_start_o        (cnsty_start),
    .integ_clear_trig_o   (integ_clear_trig),
    .cnsty_clear_trig_o   (cnsty_clear_trig),
    .chk_pending_o        (chk_pending_o),
    .chk_timeout_o        (chk_timeout_o),
    .fsm_err_o            (fsm_err_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_chk_sched.sv ====
// Check scheduler testbench with clock, reset, LCG, reference model, stimulus, checks and report
`timescale 1ns/1ps
`default_nettype none

module tb_chk_sched;

  localparam int NumPart     = 4;
  localparam int ReseedWidth = 5;

  // Cycle bounds per test
  // Run limit is their sum plus 20 percent
  localparam int ResetBound   = 100;
  localparam int OneOffBound  = 70;
  localparam int PauseBound   = 160;
  localparam int PeriodBound  = 1700;
  localparam int TimeoutBound = 120;
  localparam int EscBound     = 50;
  localparam int CycleLimit   = (ResetBound + OneOffBound + PauseBound + PeriodBound +
                                 TimeoutBound + EscBound) * 12 / 10;

  logic                                   clk_i = 1'b0;
  logic                                   rst_ni, edn_ack_i, timer_en_i, prog_busy_i;
  logic                                   integ_trig_i, cnsty_trig_i, escalate_i;
  logic [chk_sched_pkg::EdnDataWidth-1:0] edn_data_i;
  chk_sched_pkg::chk_cfg_t                cfg_i;
  logic [NumPart-1:0]                     integ_ack_i, cnsty_ack_i;
  logic                                   edn_req_o, chk_pending_o, chk_timeout_o, fsm_err_o;
  logic [NumPart-1:0]                     integ_req_o, cnsty_req_o;

  // Reference model of the request vectors
  logic [NumPart-1:0] integ_set, integ_acked, cnsty_set, cnsty_acked;
  bit                 track_en;

  string       cur_test;
  int          err_cnt, test_err_start, tests_run, tests_failed;
  int          cycle_cnt = 0;
  logic [31:0] rnd_stim, rnd_edn;

  chk_sched_top #(
    .NumPart     (NumPart),
    .ReseedWidth (ReseedWidth)
  ) UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .edn_ack_i     (edn_ack_i),
    .edn_data_i    (edn_data_i),
    .timer_en_i    (timer_en_i),
    .prog_busy_i   (prog_busy_i),
    .integ_trig_i  (integ_trig_i),
    .cnsty_trig_i  (cnsty_trig_i),
    .escalate_i    (escalate_i),
    .cfg_i         (cfg_i),
    .integ_ack_i   (integ_ack_i),
    .cnsty_ack_i   (cnsty_ack_i),
    .edn_req_o     (edn_req_o),
    .chk_pending_o (chk_pending_o),
    .chk_timeout_o (chk_timeout_o),
    .fsm_err_o     (fsm_err_o),
    .integ_req_o   (integ_req_o),
    .cnsty_req_o   (cnsty_req_o)
  );

  always #4 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CycleLimit) begin
      $display("run stopped after %0d cycles without finishing", CycleLimit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Longest wait for a mask with eight low ones and a small margin
  function automatic longint max_wait(input logic [31:0] msk);
    return (longint'(msk) << 8) + 64'd255 + 64'd4;
  endfunction

  // Bits still requesting
  function automatic logic [NumPart-1:0] exp_req(input logic [NumPart-1:0] set_bits,
                                                 input logic [NumPart-1:0] acked_bits);
    return set_bits & ~acked_bits;
  endfunction

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic report_mismatch(input string what, input int exp, input int act);
    $display("error %s %s: expected %0d actual %0d", cur_test, what, exp, act);
    err_cnt++;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  task automatic finish_test();
    tests_run++;
    if (err_cnt == test_err_start) begin
      $display("test %s: passed", cur_test);
    end else begin
      $display("test %s: failed with %0d errors", cur_test, err_cnt - test_err_start);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus and background processes
  ////////////////////////////////////////

  task automatic apply_reset();
    rst_ni      = 1'b0;
    integ_set   = '0;
    integ_acked = '0;
    cnsty_set   = '0;
    cnsty_acked = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic pulse_trigger(input bit cnsty);
    integ_trig_i = !cnsty;
    cnsty_trig_i = cnsty;
    @(negedge clk_i);
    integ_trig_i = 1'b0;
    cnsty_trig_i = 1'b0;
  endtask

  // Waits for a start and checks that all bits rose together before arming the model
  task automatic wait_req_rise(input bit cnsty, input int bound);
    int cycles;
    cycles = 0;
    while (((cnsty ? cnsty_req_o : integ_req_o) == '0) && cycles < bound) begin
      @(negedge clk_i);
      cycles++;
    end
    if ((cnsty ? cnsty_req_o : integ_req_o) == '0) begin
      report_failure($sformatf("%s: requests did not rise within %0d cycles", cur_test, bound));
    end else if ((cnsty ? cnsty_req_o : integ_req_o) !== '1) begin
      report_mismatch("request vector at start", int'({NumPart{1'b1}}),
                      int'(cnsty ? cnsty_req_o : integ_req_o));
    end
    if (cnsty) begin
      cnsty_set   = '1;
      cnsty_acked = '0;
    end else begin
      integ_set   = '1;
      integ_acked = '0;
    end
  endtask

  // Acks every partition once in random order with random gaps
  task automatic ack_all(input bit cnsty, input int max_delay);
    logic [NumPart-1:0] left, ack_bit;
    int                 pick, delay, sel, b, n;
    left = '1;
    for (n = NumPart; n > 0; n--) begin
      rnd_stim = lcg_next(rnd_stim);
      pick     = int'(rnd_stim[31:16]) % n;
      delay    = int'(rnd_stim[15:8]) % (max_delay + 1);
      sel      = -1;
      for (b = 0; b < NumPart; b++) begin
        if (left[b]) begin
          if (pick == 0 && sel < 0) sel = b;
          pick--;
        end
      end
      repeat (delay) @(negedge clk_i);
      ack_bit      = '0;
      ack_bit[sel] = 1'b1;
      if (cnsty) cnsty_ack_i = ack_bit;
      else integ_ack_i = ack_bit;
      @(negedge clk_i);
      integ_ack_i = '0;
      cnsty_ack_i = '0;
      // Bit cleared on the edge just passed
      if (cnsty) cnsty_acked = cnsty_acked | ack_bit;
      else integ_acked = integ_acked | ack_bit;
      left[sel] = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (chk_pending_o && cycles < 4) begin
      @(negedge clk_i);
      cycles++;
    end
    if (chk_pending_o) report_failure($sformatf("%s: chk_pending_o stuck high", cur_test));
  endtask

  // Entropy source with random ack delay
  task automatic edn_responder();
    forever begin
      @(negedge clk_i);
      rnd_edn    = lcg_next(rnd_edn);
      edn_ack_i  = edn_req_o & rnd_edn[31];
      edn_data_i = {rnd_edn, ~rnd_edn};
    end
  endtask

  // Request outputs against the model just after the stimulus edge
  task automatic compare_requests();
    forever begin
      @(negedge clk_i);
      #1;
      if (track_en && (integ_req_o !== exp_req(integ_set, integ_acked)))
        report_mismatch("integ_req_o", int'(exp_req(integ_set, integ_acked)), int'(integ_req_o));
      if (track_en && (cnsty_req_o !== exp_req(cnsty_set, cnsty_acked)))
        report_mismatch("cnsty_req_o", int'(exp_req(cnsty_set, cnsty_acked)), int'(cnsty_req_o));
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int cycles;
    int round;
    rst_ni       = 1'b0;
    edn_ack_i    = 1'b0;
    edn_data_i   = '0;
    timer_en_i   = 1'b0;
    prog_busy_i  = 1'b0;
    integ_trig_i = 1'b0;
    cnsty_trig_i = 1'b0;
    escalate_i   = 1'b0;
    cfg_i        = '0;
    integ_ack_i  = '0;
    cnsty_ack_i  = '0;
    track_en     = 1'b0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    rnd_stim     = 32'h91d;
    rnd_edn      = 32'h91d;
    fork
      compare_requests();
    join_none

    // Reset values and reseed period
    start_test("reset_reseed");
    apply_reset();
    if (edn_req_o !== 1'b0) report_mismatch("edn_req_o", 0, int'(edn_req_o));
    if (chk_pending_o !== 1'b0) report_mismatch("chk_pending_o", 0, int'(chk_pending_o));
    if (chk_timeout_o !== 1'b0) report_mismatch("chk_timeout_o", 0, int'(chk_timeout_o));
    if (fsm_err_o !== 1'b0) report_mismatch("fsm_err_o", 0, int'(fsm_err_o));
    if (integ_req_o !== '0) report_mismatch("integ_req_o", 0, int'(integ_req_o));
    if (cnsty_req_o !== '0) report_mismatch("cnsty_req_o", 0, int'(cnsty_req_o));
    for (round = 0; round < 2; round++) begin
      cycles = 0;
      while (!edn_req_o && cycles < 40) begin
        @(negedge clk_i);
        cycles++;
      end
      if (cycles != 31) report_mismatch("edn_req_o rise cycle", 31, cycles);
      rnd_stim   = lcg_next(rnd_stim);
      edn_data_i = {rnd_stim, ~rnd_stim};
      edn_ack_i  = 1'b1;
      @(negedge clk_i);
      edn_ack_i = 1'b0;
      if (edn_req_o !== 1'b0) report_mismatch("edn_req_o after ack", 0, int'(edn_req_o));
    end
    finish_test();
    fork
      edn_responder();
    join_none

    // Trigger only with both masks at zero
    start_test("one_off_integrity");
    timer_en_i = 1'b1;
    repeat (2) @(negedge clk_i);
    track_en = 1'b1;
    pulse_trigger(1'b0);
    wait_req_rise(1'b0, 1);
    if (chk_pending_o !== 1'b1) report_mismatch("chk_pending_o", 1, int'(chk_pending_o));
    ack_all(1'b0, 7);
    wait_idle();
    finish_test();

    // Programming holds the consistency timeout
    start_test("paused_timeout");
    cfg_i.timeout = 32'd40;
    pulse_trigger(1'b1);
    wait_req_rise(1'b1, 1);
    prog_busy_i = 1'b1;
    repeat (100) @(negedge clk_i);
    if (chk_pending_o !== 1'b1) report_mismatch("chk_pending_o while busy", 1,
                                                int'(chk_pending_o));
    prog_busy_i = 1'b0;
    ack_all(1'b1, 5);
    wait_idle();
    if (chk_timeout_o !== 1'b0) report_mismatch("chk_timeout_o", 0, int'(chk_timeout_o));
    finish_test();

    // Three periodic rounds
    start_test("periodic_integrity");
    cfg_i.timeout   = 32'd0;
    cfg_i.integ_msk = 32'd1;
    for (round = 0; round < 3; round++) begin
      wait_req_rise(1'b0, int'(max_wait(cfg_i.integ_msk)));
      ack_all(1'b0, 7);
    end
    cfg_i.integ_msk = 32'd0;
    wait_idle();
    finish_test();

    // Unanswered check runs into the timeout
    start_test("check_timeout");
    cfg_i.timeout = 32'd30;
    pulse_trigger(1'b0);
    wait_req_rise(1'b0, 1);
    cycles = 0;
    while (!chk_timeout_o && cycles < 40) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles < 30 || cycles > 33)
      report_failure($sformatf("error %s chk_timeout_o delay: expected 30 to 33 actual %0d",
                               cur_test, cycles));
    ack_all(1'b0, 3);
    pulse_trigger(1'b0);
    pulse_trigger(1'b1);
    repeat (10) @(negedge clk_i);
    if (fsm_err_o !== 1'b0) report_mismatch("fsm_err_o", 0, int'(fsm_err_o));
    if (chk_timeout_o !== 1'b1) report_mismatch("chk_timeout_o", 1, int'(chk_timeout_o));
    finish_test();

    // Escalation after a fresh reset
    start_test("escalation");
    track_en = 1'b0;
    cfg_i    = '0;
    apply_reset();
    track_en = 1'b1;
    repeat (2) @(negedge clk_i);
    escalate_i = 1'b1;
    cycles     = 0;
    while (!fsm_err_o && cycles < 4) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!fsm_err_o) report_failure($sformatf("%s: fsm_err_o never rose", cur_test));
    pulse_trigger(1'b0);
    pulse_trigger(1'b1);
    repeat (10) @(negedge clk_i);
    if (fsm_err_o !== 1'b1) report_mismatch("fsm_err_o", 1, int'(fsm_err_o));
    if (chk_timeout_o !== 1'b0) report_mismatch("chk_timeout_o", 0, int'(chk_timeout_o));
    finish_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== chk_sched.f ====
design/chk_sched_pkg.sv
design/lfsr_period_gen.sv
design/chk_wait_counter.sv
design/chk_req_tracker.sv
design/chk_sched_fsm.sv
design/chk_sched_top.sv
testbench/tb_chk_sched.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_chk_sched
FILELIST  := chk_sched.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
